// File: Makefile
SRCS := $(shell cat src.f)

obj_dir/VtbTestResources: src.f $(SRCS)
	verilator --binary --timing --assert --top-module tbTestResources -f src.f

run: obj_dir/VtbTestResources
	@out="$$(./obj_dir/VtbTestResources)"; echo "$$out"; echo "$$out" | grep -qx "TEST PASSED"

clean:
	rm -rf obj_dir

.PHONY: run clean

// File: common/memMapPkg.sv
package memMapPkg;

	localparam int wordBits = 16;

	// One data word on every CPU and block path
	typedef logic [wordBits-1:0] cpuWord;

	// Region start addresses, byte addressed
	localparam cpuWord romBase  = 16'h0000;
	localparam cpuWord ramBase  = 16'h2000;
	localparam cpuWord uartBase = 16'h4000;
	localparam cpuWord intBase  = 16'h4010;
	localparam cpuWord gpioBase = 16'h4020;

	// 4096 words of local RAM
	localparam int ramAddrBits = 12;

	// Low address bits that fall inside each window
	localparam int memSpanBits  = ramAddrBits + 1;
	localparam int regSpanBits  = 3;
	localparam int gpioSpanBits = 2;

endpackage

// File: common/periphBus.sv
`timescale 1ns/1ps

interface periphBus #(
	parameter int addrBits = 2
);

	logic rd;
	logic wr;
	logic [1:0] byteEn;
	logic [addrBits-1:0] addr;
	memMapPkg::cpuWord wrData;
	memMapPkg::cpuWord rdData;

	// Decoder side, drives one access toward a block
	modport mapper (
		output rd, wr, byteEn, addr, wrData,
		input rdData
	);

	// Block side
	modport target (
		input rd, wr, byteEn, addr, wrData,
		output rdData
	);

endinterface

// File: common/periphPkg.sv
package periphPkg;

	// Register blocks decode word offsets 0 to 3
	localparam int regAddrBits = 2;

	// UART register offsets
	localparam logic [1:0] uartData    = 2'd0;
	localparam logic [1:0] uartStatus  = 2'd1;
	localparam logic [1:0] uartDivisor = 2'd2;
	localparam logic [1:0] uartControl = 2'd3;

	// Status register bits
	localparam int rxValidBit = 0;
	localparam int txBusyBit  = 1;
	localparam int overrunBit = 2;

	// Control register bits
	localparam int rxIntEnBit = 0;

	// Clocks per bit after reset
	localparam memMapPkg::cpuWord divisorReset = 16'd16;

	// Interrupt register offsets
	localparam logic [1:0] intPending = 2'd0;
	localparam logic [1:0] intMask    = 2'd1;
	localparam logic [1:0] intClear   = 2'd2;

	// Six external lines plus the UART receive interrupt
	localparam int numIntSources = 7;

endpackage

// File: src.f
common/memMapPkg.sv
common/periphPkg.sv
common/periphBus.sv
verilog/memoryMapper.sv
verilog/busRam.sv
uart/uartCore.sv
verilog/interruptMaskRegister.sv
verilog/testResources.sv
verif/testResources_properties.sv
verif/tbTestResources.sv

// File: uart/uartCore.sv
`timescale 1ns/1ps

module uartCore (
	input logic CLK,
	input logic arstN,
	periphBus.target bus,
	input logic rxd,
	output logic txd,
	output logic rxInt
);

	memMapPkg::cpuWord divisor;
	logic rxIntEn;
	logic rxValid, overrun;
	logic [7:0] rxData;

	logic txBusy, txLine;
	logic [3:0] txCount;
	logic [8:0] txShift;
	memMapPkg::cpuWord txBaud;

	logic [1:0] rxSync;
	logic rxIn, rxActive, rxDone;
	logic [3:0] rxCount;
	logic [7:0] rxShift;
	memMapPkg::cpuWord rxBaud;

	logic dataWrite, dataRead;
	memMapPkg::cpuWord statusWord, controlWord;

	assign dataWrite = bus.wr && bus.byteEn[0] && bus.addr == periphPkg::uartData;
	assign dataRead  = bus.rd && bus.addr == periphPkg::uartData;

	always_ff @(posedge CLK or negedge arstN) begin
		if (!arstN) begin
			divisor <= periphPkg::divisorReset;
			rxIntEn <= 1'b0;
		end else if (bus.wr) begin
			if (bus.addr == periphPkg::uartDivisor) begin
				if (bus.byteEn[0])
					divisor[7:0] <= bus.wrData[7:0];
				if (bus.byteEn[1])
					divisor[15:8] <= bus.wrData[15:8];
			end else if (bus.addr == periphPkg::uartControl && bus.byteEn[0]) begin
				rxIntEn <= bus.wrData[periphPkg::rxIntEnBit];
			end
		end
	end

	// Transmitter; start bit goes out right after the write edge
	always_ff @(posedge CLK or negedge arstN) begin
		if (!arstN) begin
			txBusy <= 1'b0;
			txLine <= 1'b1;
			txCount <= '0;
			txBaud <= '0;
		end else if (!txBusy) begin
			if (dataWrite) begin
				txBusy <= 1'b1;
				txLine <= 1'b0;
				txCount <= 4'd9;
				txBaud <= divisor - 1'b1;
			end
		end else if (txBaud != '0) begin
			txBaud <= txBaud - 1'b1;
		end else if (txCount == '0) begin
			txBusy <= 1'b0; // stop bit done
		end else begin
			txLine <= txShift[0];
			txCount <= txCount - 1'b1;
			txBaud <= divisor - 1'b1;
		end
	end

	// Data bits then the stop bit, shifted out LSB first
	always_ff @(posedge CLK) begin
		if (!txBusy && dataWrite)
			txShift <= {1'b1, bus.wrData[7:0]};
		else if (txBusy && txBaud == '0 && txCount != '0)
			txShift <= {1'b1, txShift[8:1]};
	end

	assign txd = txLine;

	always_ff @(posedge CLK or negedge arstN) begin
		if (!arstN)
			rxSync <= 2'b11;
		else
			rxSync <= {rxSync[0], rxd};
	end

	assign rxIn = rxSync[1];

	// Receiver; count 0 checks the start bit, 1 to 8 data, 9 stop
	always_ff @(posedge CLK or negedge arstN) begin
		if (!arstN) begin
			rxActive <= 1'b0;
			rxCount <= '0;
			rxBaud <= '0;
		end else if (!rxActive) begin
			if (!rxIn) begin
				rxActive <= 1'b1;
				rxCount <= '0;
				rxBaud <= {1'b0, divisor[15:1]};
			end
		end else if (rxBaud != '0) begin
			rxBaud <= rxBaud - 1'b1;
		end else begin
			rxBaud <= divisor - 1'b1;
			if (rxCount == '0 && rxIn)
				rxActive <= 1'b0; // glitch, not a start bit
			else if (rxCount == 4'd9)
				rxActive <= 1'b0;
			else
				rxCount <= rxCount + 1'b1;
		end
	end

	assign rxDone = rxActive && rxBaud == '0 && rxCount == 4'd9;

	always_ff @(posedge CLK) begin
		if (rxActive && rxBaud == '0 && rxCount != '0 && rxCount != 4'd9)
			rxShift <= {rxIn, rxShift[7:1]};
		if (rxDone)
			rxData <= rxShift;
	end

	// A new byte wins over a clearing read in the same cycle
	always_ff @(posedge CLK or negedge arstN) begin
		if (!arstN) begin
			rxValid <= 1'b0;
			overrun <= 1'b0;
		end else if (rxDone) begin
			rxValid <= 1'b1;
			if (rxValid)
				overrun <= 1'b1;
		end else if (dataRead) begin
			rxValid <= 1'b0;
			overrun <= 1'b0;
		end
	end

	assign rxInt = rxValid & rxIntEn;

	always_comb begin
		statusWord = '0;
		statusWord[periphPkg::rxValidBit] = rxValid;
		statusWord[periphPkg::txBusyBit] = txBusy;
		statusWord[periphPkg::overrunBit] = overrun;
		controlWord = '0;
		controlWord[periphPkg::rxIntEnBit] = rxIntEn;
	end

	always_comb begin
		case (bus.addr)
			periphPkg::uartData: bus.rdData = {8'h00, rxData};
			periphPkg::uartStatus: bus.rdData = statusWord;
			periphPkg::uartDivisor: bus.rdData = divisor;
			default: bus.rdData = controlWord;
		endcase
	end

endmodule

// File: verif/stimulus_input.txt
# name op addr data expected, all numbers in hex
# write: expected holds the byte lanes; read: data drives gpioDin, its inverse busDin
ramBoth write 2010 a5c3 0003
ramBothRd read 2010 0000 a5c3
ramLow write 2010 0077 0001
ramLowRd read 2010 0000 a577
ramHigh write 2010 1200 0002
ramHighRd read 2010 0000 1277
ramTop write 3ffe beef 0003
ramTopRd read 3ffe 0000 beef
ramKeepRd read 2010 0000 1277
romZero readRom 0000 0000 ffff
romOdd readRom 0011 0000 fff7
romMid readRom 1abc 0000 f2a1
romTop readRom 1ffe 0000 f000
unmapped read 8000 1234 edcb
unmappedGap read 4030 5a5a a5a5
gpioRd read 4020 5a5a 5a5a
gpioHiRd read 4022 0f0f 0f0f
uartSingle uartLoop 0008 003c 003c
uartOverrun uartLoop 0008 a196 0096
intUnmask write 4012 0001 0001
intRaise raise 0000 0002 0000
intHigh checkInt 0000 0000 0001
intDrop raise 0000 0000 0000
intClear write 4014 0001 0001
intLow checkInt 0000 0000 0000
intMasked raise 0000 0004 0000
intMaskedLow checkInt 0000 0000 0000
intPendRd read 4010 0000 0002
intDropAll raise 0000 0000 0000
intClearAll write 4014 007f 0001
intNoneRd read 4010 0000 0000
int0High raise 0000 0001 0000
int0Check checkInt 0000 0000 0002
int0Drop raise 0000 0000 0000

// File: verif/tbTestResources.sv
`timescale 1ns/1ps

module tbTestResources;

	logic CLK;
	logic arstN;
	memMapPkg::cpuWord addr;
	memMapPkg::cpuWord cpuDout;
	memMapPkg::cpuWord cpuDin;
	logic rdN;
	logic wr0N;
	logic wr1N;
	memMapPkg::cpuWord busDin;
	memMapPkg::cpuWord gpioDin;
	logic rdGpio;
	logic wrGpio;
	logic addrGpio;
	logic uartRxd;
	logic uartTxd;
	logic [periphPkg::numIntSources-1:0] ints;
	logic int0;
	logic int1;
	memMapPkg::cpuWord romAddr;
	memMapPkg::cpuWord romDout;

	memMapPkg::cpuWord romTable [4096];
	int testCount;
	int failCount;
	bit testFailed;

	testResources UUT (
		.CLK(CLK),
		.arstN(arstN),
		.addr(addr),
		.cpuDout(cpuDout),
		.cpuDin(cpuDin),
		.rdN(rdN),
		.wr0N(wr0N),
		.wr1N(wr1N),
		.busDin(busDin),
		.gpioDin(gpioDin),
		.rdGpio(rdGpio),
		.wrGpio(wrGpio),
		.addrGpio(addrGpio),
		.uartRxd(uartRxd),
		.uartTxd(uartTxd),
		.ints(ints),
		.int0(int0),
		.int1(int1),
		.romAddr(romAddr),
		.romDout(romDout)
	);

	// Serial loopback
	assign uartRxd = uartTxd;

	// ROM word at each word address
	assign romDout = romTable[romAddr[12:1]];

	initial begin
		CLK = 1'b0;
		forever #20 CLK = ~CLK;
	end

	initial begin
		#2000000;
		$display("Simulation stopped by the watchdog before all tests finished");
		$display("TEST FAILED");
		$finish;
	end

	function automatic memMapPkg::cpuWord uartReg(input logic [1:0] offset);
		return memMapPkg::uartBase + 16'(2 * offset);
	endfunction

	task automatic compareWord(input string testName, input memMapPkg::cpuWord expected,
		input memMapPkg::cpuWord actual);
		if (actual !== expected) begin
			$display("MISMATCH %s expected %h actual %h", testName, expected, actual);
			testFailed = 1'b1;
		end
	endtask

	task automatic compareLine(input string testName, input logic expected,
		input logic actual);
		if (actual !== expected) begin
			$display("MISMATCH %s expected %b actual %b", testName, expected, actual);
			testFailed = 1'b1;
		end
	endtask

	// rdN held low over two edges and data sampled between them
	task automatic busRead(input memMapPkg::cpuWord a, output memMapPkg::cpuWord data,
		output logic gpioStrobe);
		@(posedge CLK);
		addr <= a;
		rdN <= 1'b0;
		@(posedge CLK);
		@(negedge CLK);
		data = cpuDin;
		gpioStrobe = rdGpio;
		@(posedge CLK);
		rdN <= 1'b1;
	endtask

	task automatic busWrite(input memMapPkg::cpuWord a, input memMapPkg::cpuWord data,
		input logic [1:0] lanes, output logic gpioStrobe);
		@(posedge CLK);
		addr <= a;
		cpuDout <= data;
		wr0N <= ~lanes[0];
		wr1N <= ~lanes[1];
		@(negedge CLK);
		gpioStrobe = wrGpio;
		@(posedge CLK);
		wr0N <= 1'b1;
		wr1N <= 1'b1;
	endtask

	task automatic pollStatus(input string testName, input int bitPos, input logic want);
		memMapPkg::cpuWord status;
		logic unusedStrobe;
		int tries;
		tries = 0;
		busRead(uartReg(periphPkg::uartStatus), status, unusedStrobe);
		while (status[bitPos] !== want && tries < 200) begin
			busRead(uartReg(periphPkg::uartStatus), status, unusedStrobe);
			tries++;
		end
		if (status[bitPos] !== want) begin
			$display("%s timed out waiting for UART status bit %0d to become %b",
				testName, bitPos, want);
			testFailed = 1'b1;
		end
	endtask

	// A nonzero high byte goes out first and is left unread
	task automatic uartLoop(input string testName, input memMapPkg::cpuWord divisor,
		input memMapPkg::cpuWord data, input memMapPkg::cpuWord expected);
		memMapPkg::cpuWord got;
		logic unusedStrobe;
		busWrite(uartReg(periphPkg::uartDivisor), divisor, 2'b11, unusedStrobe);
		if (data[15:8] != 8'h00) begin
			busWrite(uartReg(periphPkg::uartData), {8'h00, data[15:8]}, 2'b01, unusedStrobe);
			pollStatus(testName, periphPkg::txBusyBit, 1'b0);
		end
		busWrite(uartReg(periphPkg::uartData), {8'h00, data[7:0]}, 2'b01, unusedStrobe);
		if (data[15:8] != 8'h00)
			pollStatus(testName, periphPkg::overrunBit, 1'b1);
		else
			pollStatus(testName, periphPkg::rxValidBit, 1'b1);
		busRead(uartReg(periphPkg::uartData), got, unusedStrobe);
		compareWord(testName, expected, got);
		busRead(uartReg(periphPkg::uartStatus), got, unusedStrobe);
		compareLine(testName, 1'b0, got[periphPkg::rxValidBit]);
		compareLine(testName, 1'b0, got[periphPkg::overrunBit]);
		pollStatus(testName, periphPkg::txBusyBit, 1'b0);
	endtask

	task automatic raiseInts(input memMapPkg::cpuWord value);
		@(posedge CLK);
		ints <= value[periphPkg::numIntSources-1:0];
		@(posedge CLK);
	endtask

	task automatic runLine(input string testName, input string op,
		input memMapPkg::cpuWord a, input memMapPkg::cpuWord data,
		input memMapPkg::cpuWord expected);
		memMapPkg::cpuWord got;
		memMapPkg::cpuWord gpioOffset;
		logic gpioStrobe;
		logic gpioExpected;
		testFailed = 1'b0;
		gpioExpected = a[15:2] == memMapPkg::gpioBase[15:2];
		gpioOffset = a - memMapPkg::gpioBase;
		if (op == "write") begin
			busWrite(a, data, expected[1:0], gpioStrobe);
			compareLine(testName, gpioExpected, gpioStrobe);
		end else if (op == "read" || op == "readRom") begin
			@(posedge CLK);
			gpioDin <= data;
			busDin <= ~data;
			busRead(a, got, gpioStrobe);
			compareWord(testName, expected, got);
			compareLine(testName, gpioExpected, gpioStrobe);
			if (gpioExpected) begin
				// Word select inside the GPIO window
				compareLine(testName, gpioOffset[1], addrGpio);
				busWrite(a, data, 2'b11, gpioStrobe);
				compareLine(testName, 1'b1, gpioStrobe);
			end
			if (op == "readRom")
				compareWord(testName, a & 16'h1ffe, romAddr);
		end else if (op == "uartLoop") begin
			uartLoop(testName, a, data, expected);
		end else if (op == "raise") begin
			raiseInts(data);
		end else if (op == "checkInt") begin
			@(negedge CLK);
			compareLine(testName, expected[0], int1);
			compareLine(testName, expected[1], int0);
		end else begin
			$display("%s has an unknown operation %s", testName, op);
			testFailed = 1'b1;
		end
		testCount++;
		if (testFailed)
			failCount++;
		else
			$display("pass %s", testName);
	endtask

	initial begin
		int fd;
		int fields;
		string line;
		string testName;
		string op;
		memMapPkg::cpuWord a;
		memMapPkg::cpuWord d;
		memMapPkg::cpuWord e;
		arstN = 1'b1;
		addr = '0;
		cpuDout = '0;
		rdN = 1'b1;
		wr0N = 1'b1;
		wr1N = 1'b1;
		busDin = '0;
		gpioDin = '0;
		ints = '0;
		testCount = 0;
		failCount = 0;
		testFailed = 1'b0;
		for (int i = 0; i < 4096; i++)
			romTable[i] = ~16'(i);
		// Falling edge just after time zero starts the asynchronous reset
		#1;
		arstN = 1'b0;
		repeat (2) @(posedge CLK);
		arstN <= 1'b1;
		fd = $fopen("verif/stimulus_input.txt", "r");
		if (fd == 0) begin
			$display("Could not open the stimulus file verif/stimulus_input.txt");
			failCount++;
		end else begin
			while ($fgets(line, fd) != 0) begin
				fields = $sscanf(line, "%s %s %h %h %h", testName, op, a, d, e);
				if (line.getc(0) != "#" && fields == 5)
					runLine(testName, op, a, d, e);
			end
			$fclose(fd);
		end
		$display("%0d tests run, %0d failed, %0d assertion failures",
			testCount, failCount, UUT.propertiesInst.assertFailures);
		if (failCount == 0 && UUT.propertiesInst.assertFailures == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

// File: verif/testResources_properties.sv
`timescale 1ns/1ps

module testResourcesProperties (
	input logic CLK,
	input logic arstN,
	input memMapPkg::cpuWord addr,
	input memMapPkg::cpuWord cpuDout,
	input logic rdN,
	input logic wr0N,
	input logic wr1N,
	input logic uartTxd,
	input logic int1
);

	localparam memMapPkg::cpuWord maskAddr =
		memMapPkg::intBase + 16'(2 * periphPkg::intMask);

	int assertFailures = 0;
	logic [periphPkg::numIntSources-1:0] maskShadow;

	// Mask value as the CPU last wrote it through the low byte lane
	always_ff @(posedge CLK or negedge arstN) begin
		if (!arstN)
			maskShadow <= '0;
		else if (!wr0N && addr[15:1] == maskAddr[15:1])
			maskShadow <= cpuDout[periphPkg::numIntSources-1:0];
	end

	// Read and write strobes are exclusive on the CPU bus
	strobesExclusive: assert property (@(posedge CLK) disable iff (!arstN)
		!(!rdN && (!wr0N || !wr1N)))
		else begin
			assertFailures++;
			$error("rdN and a write strobe are low together");
		end

	// An empty mask enables no interrupt
	int1Masked: assert property (@(posedge CLK) disable iff (!arstN)
		(maskShadow == '0) |-> !int1)
		else begin
			assertFailures++;
			$error("int1 is high while the mask register is zero");
		end

	// Serial line idles high in reset
	txdIdleInReset: assert property (@(posedge CLK) !arstN |-> uartTxd)
		else begin
			assertFailures++;
			$error("uartTxd is low during reset");
		end

endmodule

bind testResources testResourcesProperties propertiesInst (
	.CLK(CLK),
	.arstN(arstN),
	.addr(addr),
	.cpuDout(cpuDout),
	.rdN(rdN),
	.wr0N(wr0N),
	.wr1N(wr1N),
	.uartTxd(uartTxd),
	.int1(int1)
);

// File: verilog/busRam.sv
`timescale 1ns/1ps

module busRam (
	input logic CLK,
	input logic arstN,
	periphBus.target bus
);

	localparam int depth = 2 ** memMapPkg::ramAddrBits;

	memMapPkg::cpuWord mem [depth];
	memMapPkg::cpuWord readReg;

	// Byte lanes written independently
	always_ff @(posedge CLK) begin
		if (bus.wr) begin
			if (bus.byteEn[0])
				mem[bus.addr][7:0] <= bus.wrData[7:0];
			if (bus.byteEn[1])
				mem[bus.addr][15:8] <= bus.wrData[15:8];
		end
	end

	// Word captured on the first edge of a read
	always_ff @(posedge CLK or negedge arstN) begin
		if (!arstN) begin
			readReg <= '0;
		end else if (bus.rd) begin
			readReg <= mem[bus.addr];
		end
	end

	assign bus.rdData = readReg;

endmodule

// File: verilog/interruptMaskRegister.sv
`timescale 1ns/1ps

module interruptMaskRegister (
	input logic CLK,
	input logic arstN,
	periphBus.target bus,
	input logic [periphPkg::numIntSources-1:0] sources,
	output logic int1
);

	localparam int n = periphPkg::numIntSources;

	logic [n-1:0] pending;
	logic [n-1:0] maskReg;
	logic [n-1:0] clearBits;
	logic lowWrite;

	// Registers are narrow, only the low byte lane writes them
	assign lowWrite = bus.wr && bus.byteEn[0];

	assign clearBits = (lowWrite && bus.addr == periphPkg::intClear) ?
		bus.wrData[n-1:0] : '0;

	// Sticky pending bits, a live source beats a clear
	always_ff @(posedge CLK or negedge arstN) begin
		if (!arstN)
			pending <= '0;
		else
			pending <= (pending & ~clearBits) | sources;
	end

	always_ff @(posedge CLK or negedge arstN) begin
		if (!arstN)
			maskReg <= '0;
		else if (lowWrite && bus.addr == periphPkg::intMask)
			maskReg <= bus.wrData[n-1:0];
	end

	always_comb begin
		bus.rdData = '0;
		case (bus.addr)
			periphPkg::intPending: bus.rdData[n-1:0] = pending;
			periphPkg::intMask: bus.rdData[n-1:0] = maskReg;
			default: bus.rdData = '0;
		endcase
	end

	assign int1 = |(pending & maskReg);

endmodule

// File: verilog/memoryMapper.sv
`timescale 1ns/1ps

module memoryMapper (
	input memMapPkg::cpuWord addr,
	input memMapPkg::cpuWord cpuDout,
	input logic rdN,
	input logic wr0N,
	input logic wr1N,
	output memMapPkg::cpuWord cpuDin,
	input memMapPkg::cpuWord romDout,
	input memMapPkg::cpuWord busDin,
	input memMapPkg::cpuWord gpioDin,
	output logic rdGpio,
	output logic wrGpio,
	output logic addrGpio,
	periphBus.mapper ramBus,
	periphBus.mapper uartBus,
	periphBus.mapper intBus
);

	localparam int memLow  = memMapPkg::memSpanBits;
	localparam int regLow  = memMapPkg::regSpanBits;
	localparam int gpioLow = memMapPkg::gpioSpanBits;

	logic romSel, ramSel, uartSel, intSel, gpioSel;
	logic rdAny, wrAny;
	logic [1:0] byteWr;

	assign romSel  = addr[15:memLow] == memMapPkg::romBase[15:memLow];
	assign ramSel  = addr[15:memLow] == memMapPkg::ramBase[15:memLow];
	assign uartSel = addr[15:regLow] == memMapPkg::uartBase[15:regLow];
	assign intSel  = addr[15:regLow] == memMapPkg::intBase[15:regLow];
	assign gpioSel = addr[15:gpioLow] == memMapPkg::gpioBase[15:gpioLow];

	// CPU strobes are active low
	assign rdAny  = ~rdN;
	assign byteWr = {~wr1N, ~wr0N};
	assign wrAny  = |byteWr;

	// Only the selected block sees an access
	assign ramBus.rd     = ramSel & rdAny;
	assign ramBus.wr     = ramSel & wrAny;
	assign ramBus.byteEn = ramSel ? byteWr : 2'b00;
	assign ramBus.addr   = ramSel ? addr[memMapPkg::ramAddrBits:1] : '0;
	assign ramBus.wrData = ramSel ? cpuDout : '0;

	assign uartBus.rd     = uartSel & rdAny;
	assign uartBus.wr     = uartSel & wrAny;
	assign uartBus.byteEn = uartSel ? byteWr : 2'b00;
	assign uartBus.addr   = uartSel ? addr[periphPkg::regAddrBits:1] : '0;
	assign uartBus.wrData = uartSel ? cpuDout : '0;

	assign intBus.rd     = intSel & rdAny;
	assign intBus.wr     = intSel & wrAny;
	assign intBus.byteEn = intSel ? byteWr : 2'b00;
	assign intBus.addr   = intSel ? addr[periphPkg::regAddrBits:1] : '0;
	assign intBus.wrData = intSel ? cpuDout : '0;

	// GPIO lives outside, only its strobes come from here
	assign rdGpio   = gpioSel & rdAny;
	assign wrGpio   = gpioSel & wrAny;
	assign addrGpio = addr[1];

	always_comb begin
		if (romSel)
			cpuDin = romDout;
		else if (ramSel)
			cpuDin = ramBus.rdData;
		else if (uartSel)
			cpuDin = uartBus.rdData;
		else if (intSel)
			cpuDin = intBus.rdData;
		else if (gpioSel)
			cpuDin = gpioDin;
		else
			cpuDin = busDin; // unmapped space goes to the external bus
	end

endmodule

// File: verilog/testResources.sv
`timescale 1ns/1ps

module testResources (
	input logic CLK,
	input logic arstN,

	// CPU bus
	input memMapPkg::cpuWord addr,
	input memMapPkg::cpuWord cpuDout,
	output memMapPkg::cpuWord cpuDin,
	input logic rdN,
	input logic wr0N,
	input logic wr1N,

	input memMapPkg::cpuWord busDin,

	// External GPIO port
	input memMapPkg::cpuWord gpioDin,
	output logic rdGpio,
	output logic wrGpio,
	output logic addrGpio,

	input logic uartRxd,
	output logic uartTxd,

	// Interrupt lines
	input logic [periphPkg::numIntSources-1:0] ints,
	output logic int0,
	output logic int1,

	// ROM sits outside so each test can supply its own
	output memMapPkg::cpuWord romAddr,
	input memMapPkg::cpuWord romDout
);

	logic uartInt;

	periphBus #(.addrBits(memMapPkg::ramAddrBits)) ramBus ();
	periphBus #(.addrBits(periphPkg::regAddrBits)) uartBus ();
	periphBus #(.addrBits(periphPkg::regAddrBits)) intBus ();

	assign romAddr = {3'b000, addr[12:1], 1'b0};

	memoryMapper memoryMapperInst (
		.addr(addr),
		.cpuDout(cpuDout),
		.rdN(rdN),
		.wr0N(wr0N),
		.wr1N(wr1N),
		.cpuDin(cpuDin),
		.romDout(romDout),
		.busDin(busDin),
		.gpioDin(gpioDin),
		.rdGpio(rdGpio),
		.wrGpio(wrGpio),
		.addrGpio(addrGpio),
		.ramBus(ramBus),
		.uartBus(uartBus),
		.intBus(intBus)
	);

	busRam busRamInst (
		.CLK(CLK),
		.arstN(arstN),
		.bus(ramBus)
	);

	uartCore uartCoreInst (
		.CLK(CLK),
		.arstN(arstN),
		.bus(uartBus),
		.rxd(uartRxd),
		.txd(uartTxd),
		.rxInt(uartInt)
	);

	// ints[0] bypasses the mask, the UART takes the top slot
	interruptMaskRegister interruptMaskRegisterInst (
		.CLK(CLK),
		.arstN(arstN),
		.bus(intBus),
		.sources({uartInt, ints[periphPkg::numIntSources-1:1]}),
		.int1(int1)
	);

	assign int0 = ints[0];

endmodule
